// File: common/i3c_defs.svh
// ----------------------------------------------------------------------
// I3C target front end
// Shared field widths, fixed addresses and reset values
// ----------------------------------------------------------------------

`ifndef I3C_DEFS_SVH
`define I3C_DEFS_SVH

// Filter length fields
`define I3C_TIMING_W 20

// Bus address, without and with RnW
`define I3C_ADDR_W 7
`define I3C_BYTE_W 8

// Configuration write port
`define CFG_ADDR_W 4
`define CFG_DATA_W 32

`define I3C_BCAST_ADDR 7'h7E

// Filter lengths out of reset, in clock cycles
`define T_R_RESET 20'd2
`define T_F_RESET 20'd2

`endif

// File: common/i3c_pkg.sv
// ----------------------------------------------------------------------
// I3C target front end types
// Register offsets and address receiver states
// ----------------------------------------------------------------------

`include "i3c_defs.svh"

package i3c_pkg;

  // Byte offsets, one 32-bit word per register
  typedef enum logic [`CFG_ADDR_W-1:0] {
    CFG_CTRL     = 4'h0,
    CFG_T_R      = 4'h4,
    CFG_T_F      = 4'h8,
    CFG_STA_ADDR = 4'hC
  } cfg_reg_e;

  // Address receiver FSM
  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    ACK,
    WAIT_STOP
  } addr_state_e;

endpackage

// File: common/bus_event_if.sv
// ----------------------------------------------------------------------
// Bus event interface
// Filtered SCL/SDA levels and bus conditions from the monitor
// ----------------------------------------------------------------------

`timescale 1ns/1ps

interface bus_event_if;

  // Filtered line levels
  logic scl_level;
  logic sda_level;

  // One-cycle pulses
  logic scl_rise;
  logic scl_fall;
  logic start;
  logic rstart;
  logic stop;

  // High from START to STOP
  logic busy;

  modport mon (
    output scl_level, sda_level, scl_rise, scl_fall, start, rstart, stop, busy
  );

  modport rcv (
    input scl_level, sda_level, scl_rise, scl_fall, start, rstart, stop, busy
  );

endinterface

// File: hw/bus_monitor/bus_monitor.sv
// ----------------------------------------------------------------------
// Bus monitor
// Synchronises and glitch-filters SCL and SDA, then detects START,
// repeated START and STOP and tracks whether the bus is busy
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "i3c_defs.svh"

module bus_monitor (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     scl_i,
  input  logic                     sda_i,
  input  logic                     enable_i,
  input  logic [`I3C_TIMING_W-1:0] t_r_i,
  input  logic [`I3C_TIMING_W-1:0] t_f_i,
  bus_event_if.mon                 ev
);

  localparam int unsigned line_scl = 0;
  localparam int unsigned line_sda = 1;

  logic [1:0]               line_in;
  logic [1:0]               sync_q;
  logic [1:0]               sync_qq;
  logic [1:0]               filt_q;
  logic [1:0]               filt_prev_q;
  logic [`I3C_TIMING_W-1:0] stable_cnt_q [2];
  logic [`I3C_TIMING_W-1:0] limit [2];
  logic                     busy_q;
  logic                     scl_high;
  logic                     sda_rise;
  logic                     sda_fall;

  assign line_in = {sda_i, scl_i};

  // Two-flop synchroniser, idles high like the bus
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q  <= 2'b11;
      sync_qq <= 2'b11;
    end else begin
      sync_q  <= line_in;
      sync_qq <= sync_q;
    end
  end

  // Rising edges wait t_r, falling edges t_f
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      limit[i] = sync_qq[i] ? t_r_i : t_f_i;
    end
  end

  // A new level is taken once it has held for the filter length.
  // Any return to the old level restarts the count.
  always_ff @(posedge clk_i) begin
    if (reset_i || !enable_i) begin
      filt_q      <= 2'b11;
      filt_prev_q <= 2'b11;
      for (int i = 0; i < 2; i++) begin
        stable_cnt_q[i] <= '0;
      end
    end else begin
      filt_prev_q <= filt_q;
      for (int i = 0; i < 2; i++) begin
        if (sync_qq[i] == filt_q[i]) begin
          stable_cnt_q[i] <= '0;
        end else if (stable_cnt_q[i] + 1'b1 >= limit[i]) begin
          filt_q[i]       <= sync_qq[i];
          stable_cnt_q[i] <= '0;
        end else begin
          stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // SCL must be high on both sides of the SDA edge
  assign scl_high = ev.scl_level & filt_prev_q[line_scl];
  assign sda_rise = filt_q[line_sda] & ~filt_prev_q[line_sda];
  assign sda_fall = ~filt_q[line_sda] & filt_prev_q[line_sda];

  always_ff @(posedge clk_i) begin
    if (reset_i || !enable_i) begin
      busy_q <= 1'b0;
    end else if (sda_rise && scl_high) begin
      busy_q <= 1'b0;
    end else if (sda_fall && scl_high) begin
      busy_q <= 1'b1;
    end
  end

  assign ev.scl_level = filt_q[line_scl];
  assign ev.sda_level = filt_q[line_sda];
  assign ev.scl_rise  = filt_q[line_scl] & ~filt_prev_q[line_scl];
  assign ev.scl_fall  = ~filt_q[line_scl] & filt_prev_q[line_scl];

  // START versus repeated START depends only on busy
  assign ev.start  = sda_fall & scl_high & ~busy_q;
  assign ev.rstart = sda_fall & scl_high & busy_q;
  assign ev.stop   = sda_rise & scl_high;
  assign ev.busy   = busy_q;

endmodule

// File: hw/configuration/configuration.sv
// ----------------------------------------------------------------------
// Configuration registers
// Enable, filter lengths and static address, written over valid/ready
// and locked while a transfer is on the bus
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "i3c_defs.svh"

module configuration
  import i3c_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cfg_wvalid_i,
  output logic                     cfg_wready_o,
  input  cfg_reg_e                 cfg_addr_i,
  input  logic [`CFG_DATA_W-1:0]   cfg_wdata_i,
  input  logic                     busy_i,
  output logic                     enable_o,
  output logic [`I3C_TIMING_W-1:0] t_r_o,
  output logic [`I3C_TIMING_W-1:0] t_f_o,
  output logic [`I3C_ADDR_W-1:0]   sta_addr_o,
  output logic                     sta_addr_valid_o
);

  logic                     enable_q;
  logic [`I3C_TIMING_W-1:0] t_r_q;
  logic [`I3C_TIMING_W-1:0] t_f_q;
  logic [`I3C_ADDR_W-1:0]   sta_addr_q;
  logic                     sta_addr_valid_q;
  logic                     wr_en;

  // Filters and address stay fixed for a whole transfer
  assign cfg_wready_o = ~busy_i;
  assign wr_en        = cfg_wvalid_i & cfg_wready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q         <= 1'b0;
      t_r_q            <= `T_R_RESET;
      t_f_q            <= `T_F_RESET;
      sta_addr_q       <= '0;
      sta_addr_valid_q <= 1'b0;
    end else if (wr_en) begin
      case (cfg_addr_i)
        CFG_CTRL: begin
          enable_q <= cfg_wdata_i[0];
        end
        CFG_T_R: begin
          t_r_q <= cfg_wdata_i[`I3C_TIMING_W-1:0];
        end
        CFG_T_F: begin
          t_f_q <= cfg_wdata_i[`I3C_TIMING_W-1:0];
        end
        CFG_STA_ADDR: begin
          sta_addr_q       <= cfg_wdata_i[`I3C_ADDR_W-1:0];
          sta_addr_valid_q <= cfg_wdata_i[`CFG_DATA_W-1];
        end
        // Unknown offsets complete the handshake and change nothing
        default: begin
        end
      endcase
    end
  end

  assign enable_o         = enable_q;
  assign t_r_o            = t_r_q;
  assign t_f_o            = t_f_q;
  assign sta_addr_o       = sta_addr_q;
  assign sta_addr_valid_o = sta_addr_valid_q;

endmodule

// File: hw/target_addr/target_addr_rx.sv
// ----------------------------------------------------------------------
// Target address receiver
// Shifts in the address byte after START or repeated START, ACKs a
// static or broadcast address match and hands the byte out
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "i3c_defs.svh"

module target_addr_rx
  import i3c_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`I3C_ADDR_W-1:0] sta_addr_i,
  input  logic                   sta_addr_valid_i,
  input  logic                   bus_addr_ready_i,
  bus_event_if.rcv               ev,
  output logic                   sda_o,
  output logic [`I3C_BYTE_W-1:0] bus_addr_o,
  output logic                   bus_addr_valid_o,
  output logic                   addr_overrun_o
);

  addr_state_e            state_q;
  logic [3:0]             bit_cnt_q;
  logic [`I3C_BYTE_W-1:0] shift_q;
  logic [`I3C_BYTE_W-1:0] next_byte;
  logic                   byte_done;
  logic                   addr_match;
  logic                   match_q;
  logic                   sda_q;
  logic [`I3C_BYTE_W-1:0] addr_q;
  logic                   addr_valid_q;
  logic                   overrun_q;
  logic                   addr_pending;

  // MSB first, sampled on the filtered SCL rise
  assign next_byte = {shift_q[`I3C_BYTE_W-2:0], ev.sda_level};
  assign byte_done = (state_q == SHIFT) && ev.scl_rise && (bit_cnt_q == 4'd7);

  // Broadcast always answers, static address only when valid
  assign addr_match = (next_byte[`I3C_BYTE_W-1:1] == `I3C_BCAST_ADDR) ||
                      (sta_addr_valid_i && (next_byte[`I3C_BYTE_W-1:1] == sta_addr_i));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      match_q   <= 1'b0;
      sda_q     <= 1'b1;
    end else if (ev.start || ev.rstart) begin
      state_q   <= SHIFT;
      bit_cnt_q <= '0;
      sda_q     <= 1'b1;
    end else if (ev.stop) begin
      state_q <= IDLE;
      sda_q   <= 1'b1;
    end else begin
      case (state_q)
        SHIFT: begin
          if (ev.scl_rise && (bit_cnt_q != 4'd8)) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
            if (byte_done) begin
              match_q <= addr_match;
            end
          end else if (ev.scl_fall && (bit_cnt_q == 4'd8)) begin
            // Pull SDA into the ACK slot
            state_q <= ACK;
            sda_q   <= ~match_q;
          end
        end
        ACK: begin
          if (ev.scl_fall) begin
            state_q <= WAIT_STOP;
            sda_q   <= 1'b1;
          end
        end
        IDLE, WAIT_STOP: begin
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == SHIFT) && ev.scl_rise) begin
      shift_q <= next_byte;
    end
  end

  // Pending means valid and not taken this cycle
  assign addr_pending = addr_valid_q & ~bus_addr_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      addr_valid_q <= 1'b0;
      overrun_q    <= 1'b0;
    end else if (byte_done && addr_pending) begin
      // New byte is dropped, sticky until reset
      overrun_q <= 1'b1;
    end else if (byte_done) begin
      addr_valid_q <= 1'b1;
    end else if (bus_addr_ready_i) begin
      addr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_done && !addr_pending) begin
      addr_q <= next_byte;
    end
  end

  assign sda_o            = sda_q;
  assign bus_addr_o       = addr_q;
  assign bus_addr_valid_o = addr_valid_q;
  assign addr_overrun_o   = overrun_q;

endmodule

// File: hw/i3c_target_top.sv
// ----------------------------------------------------------------------
// I3C/I2C target bus front end
// Configuration, bus monitor and address receiver
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "i3c_defs.svh"

module i3c_target_top
  import i3c_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   scl_i,
  input  logic                   sda_i,
  input  logic                   cfg_wvalid_i,
  output logic                   cfg_wready_o,
  input  logic [`CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [`CFG_DATA_W-1:0] cfg_wdata_i,
  output logic                   sda_o,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output logic                   xfer_in_progress_o,
  output logic [`I3C_BYTE_W-1:0] bus_addr_o,
  output logic                   bus_addr_valid_o,
  input  logic                   bus_addr_ready_i,
  output logic                   addr_overrun_o
);

  logic                     enable;
  logic [`I3C_TIMING_W-1:0] t_r;
  logic [`I3C_TIMING_W-1:0] t_f;
  logic [`I3C_ADDR_W-1:0]   sta_addr;
  logic                     sta_addr_valid;

  bus_event_if ev_if ();

  configuration xconfiguration (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cfg_wvalid_i     (cfg_wvalid_i),
    .cfg_wready_o     (cfg_wready_o),
    .cfg_addr_i       (cfg_reg_e'(cfg_addr_i)),
    .cfg_wdata_i      (cfg_wdata_i),
    .busy_i           (ev_if.busy),
    .enable_o         (enable),
    .t_r_o            (t_r),
    .t_f_o            (t_f),
    .sta_addr_o       (sta_addr),
    .sta_addr_valid_o (sta_addr_valid)
  );

  bus_monitor xbus_monitor (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .scl_i    (scl_i),
    .sda_i    (sda_i),
    .enable_i (enable),
    .t_r_i    (t_r),
    .t_f_i    (t_f),
    .ev       (ev_if)
  );

  target_addr_rx xtarget_addr_rx (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .sta_addr_i       (sta_addr),
    .sta_addr_valid_i (sta_addr_valid),
    .bus_addr_ready_i (bus_addr_ready_i),
    .ev               (ev_if),
    .sda_o            (sda_o),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o),
    .addr_overrun_o   (addr_overrun_o)
  );

  assign bus_start_o        = ev_if.start;
  assign bus_rstart_o       = ev_if.rstart;
  assign bus_stop_o         = ev_if.stop;
  assign xfer_in_progress_o = ev_if.busy;

endmodule

// File: tb/i3c_bus_model.svh
// ----------------------------------------------------------------------
// I2C/I3C bus model
// Controller-side tasks for START, repeated START, STOP and address
// bytes, with an optional SCL glitch inside one bit
// ----------------------------------------------------------------------

`ifndef I3C_BUS_MODEL_SVH
`define I3C_BUS_MODEL_SVH

// Lands 1 ns after the last rising edge
task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk_i);
  #1;
endtask

// SDA falls with SCL high
task automatic send_start;
  sda_drv = 1'b0;
  wait_cycles(8);
  scl_drv = 1'b0;
endtask

// Entered with SCL low after an ACK slot
task automatic send_rstart;
  wait_cycles(8);
  sda_drv = 1'b1;
  wait_cycles(8);
  scl_drv = 1'b1;
  wait_cycles(8);
  sda_drv = 1'b0;
  wait_cycles(8);
  scl_drv = 1'b0;
endtask

task automatic send_stop;
  wait_cycles(8);
  sda_drv = 1'b0;
  wait_cycles(8);
  scl_drv = 1'b1;
  wait_cycles(8);
  sda_drv = 1'b1;
  wait_cycles(8);
endtask

// SDA changes mid low phase, then one full high phase
task automatic send_bit(input logic b, input bit glitch);
  wait_cycles(4);
  sda_drv = b;
  wait_cycles(4);
  if (glitch) begin
    // Short SCL high pulse that the filter has to swallow
    scl_drv = 1'b1;
    wait_cycles(3);
    scl_drv = 1'b0;
    wait_cycles(8);
  end
  scl_drv = 1'b1;
  wait_cycles(8);
  scl_drv = 1'b0;
endtask

// Eight bits MSB first, then the ACK slot with SDA released
task automatic send_byte(input logic [7:0] b, input int glitch_bit, output logic ack);
  for (int i = 7; i >= 0; i--) begin
    send_bit(b[i], i == glitch_bit);
  end
  wait_cycles(4);
  sda_drv = 1'b1;
  wait_cycles(4);
  scl_drv = 1'b1;
  wait_cycles(4);
  ack = ~sda_o;
  wait_cycles(4);
  scl_drv = 1'b0;
endtask

`endif

// File: tb/tb_i3c_target.sv
// ----------------------------------------------------------------------
// Testbench for the I3C target bus front end
// Drives bus transfers and configuration writes, scores events,
// ACKs and reported addresses
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "i3c_defs.svh"

module tb_i3c_target
  import i3c_pkg::*;
();

  localparam logic [6:0] STA_ADDR = 7'h2A;
  // Longest transfer has two bytes and a repeated START
  localparam int XFER_CYCLES = 380;
  localparam int NUM_XFERS = 35;
  localparam int TIMEOUT_CYCLES = 2 * NUM_XFERS * XFER_CYCLES + 1000;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        scl_drv;
  logic        sda_drv;
  wire         sda_line;
  logic        cfg_wvalid_i;
  logic        cfg_wready_o;
  logic [3:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic        bus_addr_ready_i;
  logic        sda_o;
  logic        bus_start_o;
  logic        bus_rstart_o;
  logic        bus_stop_o;
  logic        xfer_in_progress_o;
  logic [7:0]  bus_addr_o;
  logic        bus_addr_valid_o;
  logic        addr_overrun_o;

  int          checks = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  int          start_seen = 0;
  int          rstart_seen = 0;
  int          stop_seen = 0;
  int          start_sent = 0;
  int          rstart_sent = 0;
  int          stop_sent = 0;
  logic        busy_model = 1'b0;
  logic        bus_enabled;
  logic [6:0]  sta_addr_cfg;
  logic        sta_valid_cfg;
  integer      seed;
  logic [7:0]  got_q[$];
  logic [7:0]  exp_q[$];

  // Open-drain bus where either side can pull SDA low
  assign sda_line = sda_drv & sda_o;

  always #5 clk_i = ~clk_i;

  i3c_target_top dut_i (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .scl_i              (scl_drv),
    .sda_i              (sda_line),
    .cfg_wvalid_i       (cfg_wvalid_i),
    .cfg_wready_o       (cfg_wready_o),
    .cfg_addr_i         (cfg_addr_i),
    .cfg_wdata_i        (cfg_wdata_i),
    .sda_o              (sda_o),
    .bus_start_o        (bus_start_o),
    .bus_rstart_o       (bus_rstart_o),
    .bus_stop_o         (bus_stop_o),
    .xfer_in_progress_o (xfer_in_progress_o),
    .bus_addr_o         (bus_addr_o),
    .bus_addr_valid_o   (bus_addr_valid_o),
    .bus_addr_ready_i   (bus_addr_ready_i),
    .addr_overrun_o     (addr_overrun_o)
  );

  `include "i3c_bus_model.svh"

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic end_run;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // Broadcast always answers and the static address only when flagged valid
  function automatic logic expect_ack(input logic [7:0] b, input logic [6:0] sta,
                                      input logic sta_valid);
    return (b[7:1] == 7'h7E) || (sta_valid && (b[7:1] == sta));
  endfunction

  // Event counts, busy window and accepted addresses
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (bus_start_o) start_seen++;
      if (bus_rstart_o) rstart_seen++;
      if (bus_stop_o) stop_seen++;
      check("xfer_in_progress_o", xfer_in_progress_o, busy_model);
      if (bus_start_o) busy_model = 1'b1;
      if (bus_stop_o) busy_model = 1'b0;
      if (cfg_wvalid_i && cfg_wready_o) begin
        check("xfer_in_progress_o on cfg write", xfer_in_progress_o, 1'b0);
      end
      if (bus_addr_valid_o && bus_addr_ready_i) begin
        got_q.push_back(bus_addr_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      errors++;
      end_run();
    end
  end

  task automatic cfg_write(input logic [3:0] addr, input logic [31:0] data);
    cfg_wvalid_i = 1'b1;
    cfg_addr_i   = addr;
    cfg_wdata_i  = data;
    @(posedge clk_i);
    while (!cfg_wready_o) @(posedge clk_i);
    #1;
    cfg_wvalid_i = 1'b0;
  endtask

  task automatic score_address(input logic [7:0] b, input logic ack);
    check("sda_o ACK", ack, bus_enabled && expect_ack(b, sta_addr_cfg, sta_valid_cfg));
    if (bus_enabled) exp_q.push_back(b);
  endtask

  task automatic do_transfer(input logic [7:0] first, input bit rstart,
                             input logic [7:0] second, input int glitch_bit);
    logic ack;
    send_start();
    send_byte(first, glitch_bit, ack);
    score_address(first, ack);
    if (rstart) begin
      send_rstart();
      send_byte(second, -1, ack);
      score_address(second, ack);
    end
    send_stop();
    wait_cycles(8);
    if (bus_enabled) begin
      start_sent++;
      stop_sent++;
      if (rstart) rstart_sent++;
    end
  endtask

  task automatic compare_counts;
    check("bus_start_o count", start_seen, start_sent);
    check("bus_rstart_o count", rstart_seen, rstart_sent);
    check("bus_stop_o count", stop_seen, stop_sent);
  endtask

  task automatic compare_addresses;
    check("bus_addr_o count", got_q.size(), exp_q.size());
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check("bus_addr_o", got_q[i], exp_q[i]);
    end
    got_q.delete();
    exp_q.delete();
  endtask

  // Broadcast and static address show up in every fifth transfer
  task automatic run_random_pass(input int n);
    logic [31:0] rnd;
    logic [7:0]  a;
    logic [7:0]  b;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      a   = rnd[7:0];
      b   = rnd[15:8];
      if (i % 5 == 0) a[7:1] = `I3C_BCAST_ADDR;
      else if (i % 5 == 1) a[7:1] = STA_ADDR;
      if (i % 3 == 0) b[7:1] = STA_ADDR;
      do_transfer(a, (i % 4 == 3), b, -1);
    end
  endtask

  initial begin
    logic [7:0] first_byte;
    int         stop_before;
    seed             = 32'h6bee;
    reset_i          = 1'b1;
    scl_drv          = 1'b1;
    sda_drv          = 1'b1;
    cfg_wvalid_i     = 1'b0;
    cfg_addr_i       = '0;
    cfg_wdata_i      = '0;
    bus_addr_ready_i = 1'b1;
    bus_enabled      = 1'b0;
    sta_addr_cfg     = '0;
    sta_valid_cfg    = 1'b0;
    wait_cycles(10);
    reset_i = 1'b0;
    wait_cycles(2);

    // Reset state and a transfer while disabled
    check("bus_start_o", bus_start_o, 1'b0);
    check("bus_rstart_o", bus_rstart_o, 1'b0);
    check("bus_stop_o", bus_stop_o, 1'b0);
    check("xfer_in_progress_o", xfer_in_progress_o, 1'b0);
    check("bus_addr_valid_o", bus_addr_valid_o, 1'b0);
    check("addr_overrun_o", addr_overrun_o, 1'b0);
    check("sda_o", sda_o, 1'b1);
    check("cfg_wready_o", cfg_wready_o, 1'b1);
    do_transfer(8'hA4, 1'b1, 8'h55, -1);
    compare_counts();
    compare_addresses();

    cfg_write(CFG_STA_ADDR, 32'h8000_0000 | STA_ADDR);
    sta_addr_cfg  = STA_ADDR;
    sta_valid_cfg = 1'b1;
    cfg_write(CFG_CTRL, 32'h1);
    bus_enabled = 1'b1;
    wait_cycles(8);

    // Events, ACKs and addresses with and without a valid static address
    run_random_pass(20);
    compare_counts();
    compare_addresses();
    cfg_write(CFG_STA_ADDR, {25'd0, STA_ADDR});
    sta_valid_cfg = 1'b0;
    run_random_pass(10);
    compare_counts();
    compare_addresses();

    // Back-pressure drops the second byte but still ACKs it
    bus_addr_ready_i = 1'b0;
    first_byte = 8'hFC;
    do_transfer(first_byte, 1'b0, 8'h00, -1);
    do_transfer(8'hFD, 1'b0, 8'h00, -1);
    check("bus_addr_valid_o", bus_addr_valid_o, 1'b1);
    check("bus_addr_o", bus_addr_o, first_byte);
    check("addr_overrun_o", addr_overrun_o, 1'b1);
    void'(exp_q.pop_back());
    bus_addr_ready_i = 1'b1;
    wait_cycles(4);
    check("bus_addr_valid_o", bus_addr_valid_o, 1'b0);
    compare_addresses();

    // Write held off until STOP
    stop_before = stop_seen;
    fork
      do_transfer(8'h91, 1'b0, 8'h00, -1);
      begin
        wait (xfer_in_progress_o === 1'b1);
        wait_cycles(1);
        cfg_write(CFG_T_R, 32'd6);
        check("bus_stop_o count at write", stop_seen - stop_before, 1);
      end
    join
    cfg_write(CFG_T_F, 32'd6);
    wait_cycles(4);

    // 3-cycle SCL glitch inside bit 3
    do_transfer(8'h6D, 1'b0, 8'h00, 3);
    compare_counts();
    compare_addresses();
    end_run();
  end

endmodule

// File: verilog.f
+incdir+common
+incdir+tb
common/i3c_pkg.sv
common/bus_event_if.sv
hw/bus_monitor/bus_monitor.sv
hw/configuration/configuration.sv
hw/target_addr/target_addr_rx.sv
hw/i3c_target_top.sv
tb/tb_i3c_target.sv
